// File: rtl/fpu_macros.svh
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// ======================================================================
// Datapath widths
// ======================================================================

// One IEEE single word
`define VALUE_W 32

// Physical register number, 64 registers with register 0 hardwired to zero
`define PREG_W 6

// Reorder buffer index
`define ROB_W 4

// Instruction word split into opcode and immediate
`define OPC_W 6
`define IMM_W 26

// ======================================================================
// Counts
// ======================================================================

// Broadcast ports seen by every operand slot, port 0 is the local result
`define NUM_SNOOP 4

// Source operands per FPU op: A, B, C and the old destination D
`define NUM_SRC 4

`endif

// File: rtl/cpuTypesPkg.sv
`include "fpu_macros.svh"

// ======================================================================
// Machine-level types shared by the whole core
// ======================================================================

package cpuTypesPkg;

	// A register value, treated as an IEEE single by the FPU
	typedef logic [`VALUE_W-1:0] value_t;

	// Physical register number after rename
	typedef logic [`PREG_W-1:0] pregNo_t;

	// Position of the op in the reorder buffer
	typedef logic [`ROB_W-1:0] robIndex_t;

	// FPU opcodes
	// The encoding sits in the low bits of the instruction word
	typedef enum logic [`OPC_W-1:0] {
		FNEG  = 6'h01,
		FABS  = 6'h02,
		FSGNJ = 6'h03,
		FMIN  = 6'h04,
		FMAX  = 6'h05,
		FMOVC = 6'h06,
		FLDI  = 6'h07
	} fpuOp_e;

	// Register form
	// All operands come from physical registers, the upper field carries nothing
	typedef struct packed {
		logic [`IMM_W-1:0] unused;
		fpuOp_e            opcode;
	} fpuRegForm_t;

	// Immediate form
	// The upper field is a constant that FLDI places in the top of the word
	typedef struct packed {
		logic [`IMM_W-1:0] imm;
		fpuOp_e            opcode;
	} fpuImmForm_t;

	// One instruction word, two decodings
	// The opcode lines up in both views, so it is always read through the
	// register form and then selects which view the rest of the word means
	typedef union packed {
		fpuRegForm_t rr;
		fpuImmForm_t ri;
	} fpuInstr_u;

endpackage

// File: rtl/fpuStationPkg.sv
`include "fpu_macros.svh"

// ======================================================================
// Transfers between dispatch, station, execute and writeback
// ======================================================================

package fpuStationPkg;

	// Slot numbers of the four operands
	// D is the old value of the destination, which FMOVC may keep
	localparam int unsigned SRC_A = 0;
	localparam int unsigned SRC_B = 1;
	localparam int unsigned SRC_C = 2;
	localparam int unsigned SRC_D = 3;

	// One physical register broadcast
	typedef struct packed {
		logic                 valid;
		cpuTypesPkg::pregNo_t preg;
		cpuTypesPkg::value_t  value;
	} snoop_t;

	// A renamed op handed to the station
	typedef struct packed {
		cpuTypesPkg::robIndex_t                 rob;
		cpuTypesPkg::fpuInstr_u                 instr;
		cpuTypesPkg::pregNo_t                   dst;
		cpuTypesPkg::pregNo_t [`NUM_SRC-1:0]    src;
	} dispatch_t;

	// An op with all operand values gathered, sent to execute
	typedef struct packed {
		cpuTypesPkg::robIndex_t                 rob;
		cpuTypesPkg::fpuInstr_u                 instr;
		cpuTypesPkg::pregNo_t                   dst;
		cpuTypesPkg::value_t [`NUM_SRC-1:0]     opnd;
	} issue_t;

	// Writeback of a finished op
	typedef struct packed {
		cpuTypesPkg::robIndex_t rob;
		cpuTypesPkg::pregNo_t   dst;
		cpuTypesPkg::value_t    value;
	} result_t;

endpackage

// File: rtl/operandSnoop.sv
`timescale 1ns/1ps
`include "fpu_macros.svh"

module operandSnoop (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    load,
	input  cpuTypesPkg::pregNo_t                    srcReg,
	input  fpuStationPkg::snoop_t [`NUM_SNOOP-1:0]  snoop,
	output logic                                    ready,
	output cpuTypesPkg::value_t                     value
);

	// Register this slot is waiting on, kept from the dispatch
	cpuTypesPkg::pregNo_t waitReg;
	// On the dispatch cycle the incoming number is compared instead
	cpuTypesPkg::pregNo_t lookReg;
	logic                 isZeroReg;
	logic                 hit;
	cpuTypesPkg::value_t  hitValue;

	assign lookReg   = load ? srcReg : waitReg;
	assign isZeroReg = (srcReg == '0);

	// Search all broadcast ports, the lowest numbered match wins
	always_comb begin
		hit      = 1'b0;
		hitValue = '0;
		for (int p = 0; p < `NUM_SNOOP; p++) begin
			if (!hit && snoop[p].valid && snoop[p].preg == lookReg) begin
				hit      = 1'b1;
				hitValue = snoop[p].value;
			end
		end
	end

	// Ready flag
	// A load restarts the slot and may complete it in the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
		end else if (load) begin
			ready <= isZeroReg || hit;
		end else if (!ready && hit) begin
			ready <= 1'b1;
		end
	end

	// Captured operand and the register it belongs to
	always_ff @(posedge clk) begin
		if (load) begin
			waitReg <= srcReg;
			if (isZeroReg)
				value <= '0;  // r0 reads as zero
			else if (hit)
				value <= hitValue;
		end else if (!ready && hit) begin
			value <= hitValue;
		end
	end

endmodule

// File: rtl/fpuStation.sv
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuStation (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    dispatchValid,
	input  fpuStationPkg::dispatch_t                dispatch,
	input  fpuStationPkg::snoop_t [`NUM_SNOOP-1:0]  snoop,
	output logic                                    stationIdle,
	output logic                                    issueValid,
	output fpuStationPkg::issue_t                   issue
);

	// ==================================================================
	// Occupancy
	// ==================================================================

	// Set from acceptance until the issue edge
	logic busy;
	// Dispatch taken this cycle
	logic accept;
	// Every operand slot holds its value
	logic allReady;

	// The station is the only place that decides whether an op is taken
	// A strobe that arrives while busy is dropped here
	assign stationIdle = !busy;
	assign accept      = dispatchValid && stationIdle;

	// ==================================================================
	// Operand slots
	// ==================================================================

	logic [`NUM_SRC-1:0]                slotReady;
	cpuTypesPkg::value_t [`NUM_SRC-1:0] slotValue;

	// One snooping slot per source, D included
	for (genvar s = 0; s < `NUM_SRC; s++) begin : g_slot
		operandSnoop i_slot (
			.clk    (clk),
			.rst    (rst),
			.load   (accept),
			.srcReg (dispatch.src[s]),
			.snoop  (snoop),
			.ready  (slotReady[s]),
			.value  (slotValue[s])
		);
	end

	assign allReady = &slotReady;

	// ==================================================================
	// Control
	// ==================================================================

	// The issue strobe is registered, so it rises one cycle after the
	// last slot turns ready
	// Busy drops on the same edge, which lets a new op in during the
	// issue cycle while the held fields stay put for execute
	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			issueValid <= 1'b0;
		end else begin
			issueValid <= busy && allReady;
			if (accept)
				busy <= 1'b1;
			else if (busy && allReady)
				busy <= 1'b0;
		end
	end

	// ==================================================================
	// Held op fields
	// ==================================================================

	cpuTypesPkg::robIndex_t heldRob;
	cpuTypesPkg::fpuInstr_u heldInstr;
	cpuTypesPkg::pregNo_t   heldDst;

	// Captured once per dispatch, read by execute in the issue cycle
	always_ff @(posedge clk) begin
		if (accept) begin
			heldRob   <= dispatch.rob;
			heldInstr <= dispatch.instr;
			heldDst   <= dispatch.dst;
		end
	end

	// The issue word is built straight from registers
	// Operand values come from the slot flops, nothing else sits between
	assign issue.rob   = heldRob;
	assign issue.instr = heldInstr;
	assign issue.dst   = heldDst;
	assign issue.opnd  = slotValue;

endmodule

// File: rtl/fpuExecute.sv
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuExecute (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    issueValid,
	input  fpuStationPkg::issue_t   issue,
	output logic                    resultValid,
	output fpuStationPkg::result_t  result
);

	// Sign-magnitude ordering of two singles
	// Negative zero orders below positive zero
	function automatic logic smLess(
		input cpuTypesPkg::value_t a,
		input cpuTypesPkg::value_t b
	);
		logic aNeg;
		logic bNeg;
		aNeg = a[`VALUE_W-1];
		bNeg = b[`VALUE_W-1];
		if (aNeg != bNeg)
			return aNeg;
		// Same sign, so the larger magnitude is smaller when negative
		if (aNeg)
			return a[`VALUE_W-2:0] > b[`VALUE_W-2:0];
		return a[`VALUE_W-2:0] < b[`VALUE_W-2:0];
	endfunction

	// ==================================================================
	// Stage 1, decode
	// ==================================================================

	logic                   s1Valid;
	cpuTypesPkg::fpuOp_e    s1Op;
	logic [`IMM_W-1:0]      s1Imm;
	cpuTypesPkg::robIndex_t s1Rob;
	cpuTypesPkg::pregNo_t   s1Dst;
	cpuTypesPkg::value_t    s1A;
	cpuTypesPkg::value_t    s1B;
	cpuTypesPkg::value_t    s1C;
	cpuTypesPkg::value_t    s1D;

	// The opcode picks the view, only FLDI reads the word as immediate
	always_ff @(posedge clk) begin
		if (issueValid) begin
			s1Op  <= issue.instr.rr.opcode;
			s1Imm <= (issue.instr.rr.opcode == cpuTypesPkg::FLDI) ? issue.instr.ri.imm : '0;
			s1Rob <= issue.rob;
			s1Dst <= issue.dst;
			s1A   <= issue.opnd[fpuStationPkg::SRC_A];
			s1B   <= issue.opnd[fpuStationPkg::SRC_B];
			s1C   <= issue.opnd[fpuStationPkg::SRC_C];
			s1D   <= issue.opnd[fpuStationPkg::SRC_D];
		end
	end

	// ==================================================================
	// Stage 2, form the value
	// ==================================================================

	logic                aLess;
	cpuTypesPkg::value_t s2Value;

	assign aLess = smLess(s1A, s1B);

	always_comb begin
		case (s1Op)
			cpuTypesPkg::FNEG:  s2Value = {~s1A[`VALUE_W-1], s1A[`VALUE_W-2:0]};
			cpuTypesPkg::FABS:  s2Value = {1'b0, s1A[`VALUE_W-2:0]};
			cpuTypesPkg::FSGNJ: s2Value = {s1B[`VALUE_W-1], s1A[`VALUE_W-2:0]};
			cpuTypesPkg::FMIN:  s2Value = aLess ? s1A : s1B;
			cpuTypesPkg::FMAX:  s2Value = aLess ? s1B : s1A;
			// Condition is the whole C word, any set bit selects A
			cpuTypesPkg::FMOVC: s2Value = (s1C != '0) ? s1A : s1D;
			cpuTypesPkg::FLDI:  s2Value = {s1Imm, {(`VALUE_W-`IMM_W){1'b0}}};
			default:            s2Value = '0;
		endcase
	end

	// Result word, held after the strobe until the next op lands
	always_ff @(posedge clk) begin
		if (s1Valid) begin
			result.rob   <= s1Rob;
			result.dst   <= s1Dst;
			result.value <= s2Value;
		end
	end

	// Strobe pipeline, two edges from issue to writeback
	always_ff @(posedge clk) begin
		if (rst) begin
			s1Valid     <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			s1Valid     <= issueValid;
			resultValid <= s1Valid;
		end
	end

endmodule

// File: rtl/fpuIssueTop.sv
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuIssueTop (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    dispatchValid,
	input  fpuStationPkg::dispatch_t                dispatch,
	output logic                                    stationIdle,
	input  fpuStationPkg::snoop_t [`NUM_SNOOP-2:0]  snoopExt,
	output logic                                    resultValid,
	output fpuStationPkg::result_t                  result
);

	// Station to execute
	logic                  issueValid;
	fpuStationPkg::issue_t issue;

	// Local result seen as a broadcast
	fpuStationPkg::snoop_t                   resultSnoop;
	fpuStationPkg::snoop_t [`NUM_SNOOP-1:0]  snoop;

	// Port 0 is the execute result, so a dependent op can wake up without
	// any outside broadcast; external ports fill 1 and up
	assign resultSnoop.valid = resultValid;
	assign resultSnoop.preg  = result.dst;
	assign resultSnoop.value = result.value;
	assign snoop             = {snoopExt, resultSnoop};

	fpuStation i_station (
		.clk           (clk),
		.rst           (rst),
		.dispatchValid (dispatchValid),
		.dispatch      (dispatch),
		.snoop         (snoop),
		.stationIdle   (stationIdle),
		.issueValid    (issueValid),
		.issue         (issue)
	);

	fpuExecute i_execute (
		.clk         (clk),
		.rst         (rst),
		.issueValid  (issueValid),
		.issue       (issue),
		.resultValid (resultValid),
		.result      (result)
	);

endmodule

// File: test/fpuIssue_asserts.sv
`timescale 1ns/1ps

module fpuIssue_asserts (
	input logic                   clk,
	input logic                   rst,
	input logic                   dispatchValid,
	input logic                   stationIdle,
	input logic                   issueValid,
	input fpuStationPkg::issue_t  issue,
	input logic                   resultValid,
	input fpuStationPkg::result_t result
);

	// Failures seen so far, read by the testbench at the end of each test
	int unsigned failCount = 0;

	// ==================================================================
	// Dispatch protocol
	// ==================================================================

	// No back-pressure, so the dispatcher has to respect stationIdle
	dispatchWhileBusy: assert property (@(posedge clk) disable iff (rst)
		dispatchValid |-> stationIdle)
	else begin
		$error("dispatch strobe arrived while the station was busy");
		failCount++;
	end

	// An accepted op makes the station busy right away
	busyAfterAccept: assert property (@(posedge clk) disable iff (rst)
		(dispatchValid && stationIdle) |=> !stationIdle)
	else begin
		$error("station still idle in the cycle after an accepted dispatch");
		failCount++;
	end

	// Idle only comes back together with the issue strobe
	idleReturnsAtIssue: assert property (@(posedge clk) disable iff (rst)
		$rose(stationIdle) |-> issueValid)
	else begin
		$error("station went idle without issuing its op");
		failCount++;
	end

	issueOnlyWhenIdle: assert property (@(posedge clk) disable iff (rst)
		issueValid |-> stationIdle)
	else begin
		$error("issue strobe while the station still reads as busy");
		failCount++;
	end

	// Operands must be real values when they leave the station
	issueKnown: assert property (@(posedge clk) disable iff (rst)
		issueValid |-> !$isunknown(issue))
	else begin
		$error("issued op carries unknown bits");
		failCount++;
	end

	// ==================================================================
	// Execute pipeline
	// ==================================================================

	// Two stages, so the writeback strobe trails the issue by two cycles
	resultAfterIssue: assert property (@(posedge clk) disable iff (rst)
		issueValid |-> ##2 resultValid)
	else begin
		$error("no result two cycles after an issue");
		failCount++;
	end

	resultTags: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> $past(issueValid, 2) && result.rob == $past(issue.rob, 2)
			&& result.dst == $past(issue.dst, 2))
	else begin
		$error("result strobe does not match the op issued two cycles earlier");
		failCount++;
	end

	// State straight out of reset
	idleAfterReset: assert property (@(posedge clk)
		$fell(rst) |-> stationIdle && !issueValid && !resultValid)
	else begin
		$error("station not idle or strobes active right after reset");
		failCount++;
	end

endmodule

// File: test/fpuIssueTb.sv
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuIssueTb;

	// ==================================================================
	// Run limits
	// ==================================================================

	localparam time CLK_PERIOD  = 40;
	localparam time DRIVE_DELAY = 2;
	localparam int  NUM_TESTS   = 6;
	// The op sweep is longest, 16 dispatches at two cycles each plus drain
	localparam int  LONGEST_SEQ    = 48;
	localparam int  TIMEOUT_CYCLES = NUM_TESTS * LONGEST_SEQ * 2;
	localparam cpuTypesPkg::value_t SIGN_BIT = {1'b1, {(`VALUE_W-1){1'b0}}};

	typedef cpuTypesPkg::pregNo_t [`NUM_SRC-1:0] srcSet_t;

	// What the reference model expects from one dispatched op
	typedef struct packed {
		cpuTypesPkg::robIndex_t             rob;
		cpuTypesPkg::pregNo_t               dst;
		cpuTypesPkg::value_t                value;
		cpuTypesPkg::value_t [`NUM_SRC-1:0] opnd;
		int                                 acceptCycle;
		int                                 latency;
	} expect_t;

	logic                                   clk;
	logic                                   rst;
	logic                                   dispatchValid;
	fpuStationPkg::dispatch_t               dispatch;
	logic                                   stationIdle;
	fpuStationPkg::snoop_t [`NUM_SNOOP-2:0] snoopExt;
	logic                                   resultValid;
	fpuStationPkg::result_t                 result;

	expect_t                issueQ[$];
	expect_t                resultQ[$];
	// Known contents of every physical register, as the model sees them
	cpuTypesPkg::value_t    regVal [2**`PREG_W];
	cpuTypesPkg::robIndex_t nextRob;
	cpuTypesPkg::pregNo_t   nextSrc;
	cpuTypesPkg::pregNo_t   nextDst;
	int unsigned            seed;
	int                     cycle = 0;
	int                     errors;
	int                     checks;
	int                     testsBad;
	int                     errorsAtStart;
	string                  testName;

	fpuIssueTop i_dut (
		.clk           (clk),
		.rst           (rst),
		.dispatchValid (dispatchValid),
		.dispatch      (dispatch),
		.stationIdle   (stationIdle),
		.snoopExt      (snoopExt),
		.resultValid   (resultValid),
		.result        (result)
	);

	bind fpuIssueTop fpuIssue_asserts i_asserts (
		.clk           (clk),
		.rst           (rst),
		.dispatchValid (dispatchValid),
		.stationIdle   (stationIdle),
		.issueValid    (issueValid),
		.issue         (issue),
		.resultValid   (resultValid),
		.result        (result)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// Cycle count doubles as the watchdog
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d results never arrived", cycle, resultQ.size());
			$display("test failed");
			$finish;
		end
	end

	// ==================================================================
	// Reference model
	// ==================================================================

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Random single of the given sign, bit 23 set keeps it away from zero
	function automatic cpuTypesPkg::value_t randValue(input logic neg);
		logic [31:0] r;
		r = nextRand();
		return {neg, r[`VALUE_W-2:0] | 31'h0080_0000};
	endfunction

	// Maps sign-magnitude onto an unsigned order, -0 sits just below +0
	function automatic cpuTypesPkg::value_t orderKey(input cpuTypesPkg::value_t x);
		return x[`VALUE_W-1] ? ~x : (x | SIGN_BIT);
	endfunction

	function automatic cpuTypesPkg::value_t refValue(
		input cpuTypesPkg::fpuOp_e                op,
		input logic [`IMM_W-1:0]                  imm,
		input cpuTypesPkg::value_t [`NUM_SRC-1:0] v
	);
		case (op)
			cpuTypesPkg::FNEG:  return v[0] ^ SIGN_BIT;
			cpuTypesPkg::FABS:  return v[0] & ~SIGN_BIT;
			cpuTypesPkg::FSGNJ: return (v[0] & ~SIGN_BIT) | (v[1] & SIGN_BIT);
			cpuTypesPkg::FMIN:  return (orderKey(v[0]) <= orderKey(v[1])) ? v[0] : v[1];
			cpuTypesPkg::FMAX:  return (orderKey(v[0]) >= orderKey(v[1])) ? v[0] : v[1];
			cpuTypesPkg::FMOVC: return (v[2] != '0) ? v[0] : v[3];
			cpuTypesPkg::FLDI:  return cpuTypesPkg::value_t'(imm) << (`VALUE_W - `IMM_W);
			default:            return '0;
		endcase
	endfunction

	// Broadcast sources stay in 1..31 and destinations in 32..63, so a
	// result on port 0 never wakes an op that waits on an outside register
	function automatic cpuTypesPkg::pregNo_t freshSrc();
		nextSrc = (nextSrc == 31) ? 6'd1 : nextSrc + 6'd1;
		return nextSrc;
	endfunction

	function automatic cpuTypesPkg::pregNo_t freshDst();
		nextDst = (nextDst == 63) ? 6'd32 : nextDst + 6'd1;
		return nextDst;
	endfunction

	function automatic int totalErrors();
		return errors + i_dut.i_asserts.failCount;
	endfunction

	task automatic checkField(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("FAIL %s %s: expected %h, actual %h", testName, what, exp, act);
			errors++;
		end
	endtask

	// Station output and writeback, looked at mid-cycle
	always @(negedge clk) begin : watchOutputs
		expect_t e;
		if (!rst && i_dut.issueValid) begin
			if (issueQ.size() == 0) begin
				$display("%s: the station issued an op that was never dispatched", testName);
				errors++;
			end else begin
				e = issueQ.pop_front();
				for (int s = 0; s < `NUM_SRC; s++)
					checkField($sformatf("operand %0d", s), e.opnd[s], i_dut.issue.opnd[s]);
				checkField("issue cycle", e.acceptCycle + e.latency - 2, cycle);
			end
		end
		if (!rst && resultValid) begin
			if (resultQ.size() == 0) begin
				$display("%s: a result appeared with no op outstanding", testName);
				errors++;
			end else begin
				e = resultQ.pop_front();
				checkField("rob", e.rob, result.rob);
				checkField("dst", e.dst, result.dst);
				checkField("value", e.value, result.value);
				checkField("result cycle", e.acceptCycle + e.latency, cycle);
			end
		end
	end

	// ==================================================================
	// Stimulus
	// ==================================================================

	task automatic stepCycle();
		@(posedge clk);
		#DRIVE_DELAY;
		snoopExt = '0;
	endtask

	task automatic driveBroadcast(input int port, input cpuTypesPkg::pregNo_t preg);
		snoopExt[port] = {1'b1, preg, regVal[preg]};
	endtask

	// Waits for idle, then strobes one op
	// Sources flagged in nowMask are broadcast in the dispatch cycle itself
	task automatic dispatchOp(
		input cpuTypesPkg::fpuOp_e  op,
		input logic [`IMM_W-1:0]    imm,
		input cpuTypesPkg::pregNo_t dst,
		input srcSet_t              src,
		input logic [`NUM_SRC-1:0]  nowMask,
		input int                   latency
	);
		expect_t     e;
		logic [31:0] junk;
		int          port;
		while (!stationIdle)
			stepCycle();
		junk = nextRand();
		dispatch.rob = nextRob;
		dispatch.dst = dst;
		dispatch.src = src;
		// FLDI reads the upper field as its constant, other ops must ignore the noise there
		if (op == cpuTypesPkg::FLDI)
			dispatch.instr.ri = {imm, op};
		else
			dispatch.instr.rr = {junk[`IMM_W-1:0], op};
		port = 0;
		for (int s = 0; s < `NUM_SRC; s++) begin
			e.opnd[s] = (src[s] == '0) ? '0 : regVal[src[s]];
			if (nowMask[s] && src[s] != '0) begin
				driveBroadcast(port, src[s]);
				port++;
			end
		end
		e.rob         = nextRob;
		e.dst         = dst;
		e.value       = refValue(op, imm, e.opnd);
		e.acceptCycle = cycle + 1;
		e.latency     = latency;
		regVal[dst]   = e.value;
		issueQ.push_back(e);
		resultQ.push_back(e);
		nextRob++;
		dispatchValid = 1'b1;
		stepCycle();
		dispatchValid = 1'b0;
	endtask

	// An op whose operands are all r0 or broadcast with the dispatch
	task automatic readyOp(input cpuTypesPkg::fpuOp_e op, input logic negA, input logic negB,
			input logic condTrue);
		srcSet_t     src;
		logic [31:0] r;
		src = '0;
		src[0] = freshSrc();
		regVal[src[0]] = randValue(negA);
		if (op inside {cpuTypesPkg::FSGNJ, cpuTypesPkg::FMIN, cpuTypesPkg::FMAX}) begin
			src[1] = freshSrc();
			regVal[src[1]] = randValue(negB);
		end
		if (op == cpuTypesPkg::FMOVC) begin
			src[3] = freshSrc();
			regVal[src[3]] = randValue(negB);
			if (condTrue) begin
				src[2] = freshSrc();
				regVal[src[2]] = randValue(1'b0);
			end
		end
		r = nextRand();
		dispatchOp(op, r[`IMM_W-1:0], freshDst(), src, '1, 3);
	endtask

	task automatic startTest(input string name);
		testName      = name;
		errorsAtStart = totalErrors();
	endtask

	task automatic finishTest();
		while (issueQ.size() != 0 || resultQ.size() != 0)
			stepCycle();
		stepCycle();
		if (totalErrors() == errorsAtStart) begin
			$display("%s: ok", testName);
		end else begin
			$display("%s: %0d errors", testName, totalErrors() - errorsAtStart);
			testsBad++;
		end
	endtask

	// ==================================================================
	// Tests
	// ==================================================================

	task automatic testReset();
		startTest("reset");
		checkField("stationIdle", 1, stationIdle);
		checkField("issueValid", 0, i_dut.issueValid);
		checkField("resultValid", 0, resultValid);
		finishTest();
	endtask

	task automatic testReady();
		startTest("ready");
		readyOp(cpuTypesPkg::FNEG, 1'b1, 1'b0, 1'b0);
		readyOp(cpuTypesPkg::FSGNJ, 1'b0, 1'b1, 1'b0);
		readyOp(cpuTypesPkg::FMOVC, 1'b0, 1'b0, 1'b1);
		// Every source is r0, so FMOVC falls back to a zero D
		dispatchOp(cpuTypesPkg::FMOVC, '0, freshDst(), '0, '0, 3);
		finishTest();
	endtask

	task automatic testDelayed();
		srcSet_t              src;
		cpuTypesPkg::pregNo_t other;
		startTest("delayed");
		for (int s = 0; s < `NUM_SRC; s++) begin
			src[s] = freshSrc();
			regVal[src[s]] = randValue(s[0]);
		end
		other = freshSrc();
		regVal[other] = randValue(1'b1);
		// Operands arrive on edges 1, 2 and 3 after acceptance, with noise on port 2
		dispatchOp(cpuTypesPkg::FMOVC, '0, freshDst(), src, '0, 6);
		driveBroadcast(0, src[2]);
		driveBroadcast(1, other);
		stepCycle();
		driveBroadcast(0, src[0]);
		driveBroadcast(2, src[1]);
		stepCycle();
		driveBroadcast(2, src[3]);
		stepCycle();
		src = '0;
		src[0] = freshSrc();
		src[1] = freshSrc();
		regVal[src[0]] = randValue(1'b0);
		regVal[src[1]] = randValue(1'b1);
		dispatchOp(cpuTypesPkg::FMAX, '0, freshDst(), src, '0, 5);
		driveBroadcast(1, src[1]);
		stepCycle();
		driveBroadcast(0, src[0]);
		stepCycle();
		finishTest();
	endtask

	task automatic testOps();
		logic [31:0] r;
		startTest("ops");
		for (int op = 1; op <= 7; op++) begin
			r = nextRand();
			readyOp(cpuTypesPkg::fpuOp_e'(op), r[0], r[1], 1'b1);
		end
		// Every sign pairing for the compare-select ops
		for (int signs = 0; signs < 4; signs++) begin
			readyOp(cpuTypesPkg::FMIN, signs[0], signs[1], 1'b0);
			readyOp(cpuTypesPkg::FMAX, signs[0], signs[1], 1'b0);
		end
		readyOp(cpuTypesPkg::FMOVC, 1'b0, 1'b1, 1'b0);
		finishTest();
	endtask

	// Each link waits only on the previous result through port 0
	task automatic testChain();
		srcSet_t     src;
		logic [31:0] r;
		startTest("chain");
		r = nextRand();
		dispatchOp(cpuTypesPkg::FLDI, r[`IMM_W-1:0] | 26'd1, 6'd40, '0, '0, 3);
		src = '0;
		src[0] = 6'd40;
		dispatchOp(cpuTypesPkg::FNEG, '0, 6'd41, src, '0, 5);
		src[0] = 6'd41;
		dispatchOp(cpuTypesPkg::FABS, '0, 6'd42, src, '0, 5);
		src[0] = 6'd42;
		src[2] = 6'd42;
		dispatchOp(cpuTypesPkg::FMOVC, '0, 6'd43, src, '0, 5);
		finishTest();
	endtask

	task automatic testIdle();
		srcSet_t src;
		startTest("idle");
		src = '0;
		src[0] = freshSrc();
		regVal[src[0]] = randValue(1'b1);
		dispatchOp(cpuTypesPkg::FABS, '0, freshDst(), src, '0, 6);
		checkField("stationIdle after accept", 0, stationIdle);
		stepCycle();
		checkField("stationIdle while waiting", 0, stationIdle);
		stepCycle();
		driveBroadcast(2, src[0]);
		stepCycle();
		checkField("stationIdle with operands ready", 0, stationIdle);
		stepCycle();
		checkField("stationIdle at issue", 1, stationIdle);
		// Strobed in the issue cycle, so it must be taken at once
		readyOp(cpuTypesPkg::FNEG, 1'b0, 1'b0, 1'b0);
		checkField("stationIdle after second accept", 0, stationIdle);
		finishTest();
	endtask

	initial begin
		clk           = 1'b0;
		rst           = 1'b1;
		dispatchValid = 1'b0;
		dispatch      = '0;
		snoopExt      = '0;
		seed          = 81288;
		errors        = 0;
		checks        = 0;
		testsBad      = 0;
		nextRob       = '0;
		nextSrc       = '0;
		nextDst       = 6'd31;
		foreach (regVal[i])
			regVal[i] = '0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		testReset();
		testReady();
		testDelayed();
		testOps();
		testChain();
		testIdle();
		$display("tests %0d, failing %0d, checks %0d, errors %0d", NUM_TESTS, testsBad, checks,
			totalErrors());
		if (testsBad == 0 && totalErrors() == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: fpuIssue.f
+incdir+rtl
rtl/cpuTypesPkg.sv
rtl/fpuStationPkg.sv
rtl/operandSnoop.sv
rtl/fpuStation.sv
rtl/fpuExecute.sv
rtl/fpuIssueTop.sv
test/fpuIssue_asserts.sv
test/fpuIssueTb.sv
